/* rtl/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

  typedef logic [6:0]  sprite_idx_t;
  typedef logic [7:0]  param_addr_t;
  typedef logic [31:0] param_word_t;
  typedef logic [8:0]  screen_x_t;
  typedef logic [7:0]  screen_y_t;
  typedef logic [1:0]  tile_size_t;
  typedef logic [7:0]  tile_dim_t;
  typedef logic [3:0]  tile_bank_t;
  typedef logic [11:0] tile_idx_t;
  typedef logic [15:0] tile_addr_t;
  typedef logic [7:0]  pal_idx_t;
  typedef logic [1:0]  pal_bank_t;
  typedef logic [3:0]  pal_no_t;
  typedef logic [9:0]  pal_addr_t;
  typedef logic [31:0] color_t;

  // attribute word 0
  localparam int W0_EN_BIT    = 31;
  localparam int W0_SIZE_LSB  = 24;
  localparam int W0_X_LSB     = 8;
  localparam int W0_Y_LSB     = 0;

  // attribute word 1
  localparam int W1_TBANK_LSB = 28;
  localparam int W1_TIDX_LSB  = 16;
  localparam int W1_PMODE_BIT = 6;
  localparam int W1_PBANK_LSB = 4;
  localparam int W1_PNO_LSB   = 0;

  localparam int ATTR_WORDS   = 2;
  localparam int HW_TILE_W    = 8;
  localparam int HW_TILE_H    = 8;

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_RD0,
    FS_RD1,
    FS_DECIDE,
    FS_WAIT_ROOM
  } fetch_state_t;

  // square sprites of 8 << size code pixels
  function automatic tile_dim_t size_to_dim(tile_size_t size);
    return tile_dim_t'(HW_TILE_W) << size;
  endfunction

endpackage

`default_nettype wire

/* rtl/sprite_attr_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface sprite_attr_if
  import sprite_pkg::*;
();

  // queue head is valid while empty is low
  logic       enable;
  tile_size_t size;
  screen_x_t  x;
  screen_y_t  y;
  tile_bank_t tile_bank;
  tile_idx_t  tile_idx;
  logic       pal_mode;
  pal_bank_t  pal_bank;
  pal_no_t    pal_no;
  logic       empty;
  logic       pop;

  modport source (
    output enable, size, x, y, tile_bank, tile_idx, pal_mode, pal_bank, pal_no, empty,
    input  pop
  );

  modport sink (
    input  enable, size, x, y, tile_bank, tile_idx, pal_mode, pal_bank, pal_no, empty,
    output pop
  );

endinterface

`default_nettype wire

/* rtl/sprite_attr_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

module sprite_attr_fetch
  import sprite_pkg::*;
#(
  parameter int SPRITE_COUNT = 128
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              line_start,
  input  wire screen_y_t   line_y,
  output logic             scan_done,
  output screen_y_t        cur_y,
  output logic             param_en,
  output param_addr_t      param_addr,
  input  wire param_word_t param_data,
  output logic             push,
  output logic             rec_enable,
  output tile_size_t       rec_size,
  output screen_x_t        rec_x,
  output screen_y_t        rec_y,
  output tile_bank_t       rec_tile_bank,
  output tile_idx_t        rec_tile_idx,
  output logic             rec_pal_mode,
  output pal_bank_t        rec_pal_bank,
  output pal_no_t          rec_pal_no,
  input  wire              full
);

  fetch_state_t state;
  sprite_idx_t  idx;
  logic         w1_sent;
  param_word_t  hold_w0;
  param_word_t  hold_w1;
  logic [8:0]   y_end;
  logic         covers;
  logic         last_idx;
  logic         advance;

  // word 0 goes out in RD0 and word 1 in the first RD1 cycle
  assign param_en   = (state == FS_RD0) || (state == FS_RD1 && !w1_sent);
  assign param_addr = param_addr_t'(ATTR_WORDS * idx) + param_addr_t'(state == FS_RD1);

  assign rec_enable    = hold_w0[W0_EN_BIT];
  assign rec_size      = hold_w0[W0_SIZE_LSB +: $bits(tile_size_t)];
  assign rec_x         = hold_w0[W0_X_LSB +: $bits(screen_x_t)];
  assign rec_y         = hold_w0[W0_Y_LSB +: $bits(screen_y_t)];
  assign rec_tile_bank = hold_w1[W1_TBANK_LSB +: $bits(tile_bank_t)];
  assign rec_tile_idx  = hold_w1[W1_TIDX_LSB +: $bits(tile_idx_t)];
  assign rec_pal_mode  = hold_w1[W1_PMODE_BIT];
  assign rec_pal_bank  = hold_w1[W1_PBANK_LSB +: $bits(pal_bank_t)];
  assign rec_pal_no    = hold_w1[W1_PNO_LSB +: $bits(pal_no_t)];

  // y + dim kept at 9 bits so it cannot wrap
  assign y_end    = {1'b0, rec_y} + {1'b0, size_to_dim(rec_size)};
  assign covers   = rec_enable && (cur_y >= rec_y) && ({1'b0, cur_y} < y_end);
  assign last_idx = (idx == sprite_idx_t'(SPRITE_COUNT - 1));

  assign push    = covers && !full && (state == FS_DECIDE || state == FS_WAIT_ROOM);
  assign advance = (!covers || !full) && (state == FS_DECIDE || state == FS_WAIT_ROOM);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= FS_IDLE;
      idx       <= '0;
      w1_sent   <= 1'b0;
      scan_done <= 1'b1;
      cur_y     <= '0;
    end else begin
      case (state)
        FS_IDLE: begin
          if (line_start) begin
            state     <= FS_RD0;
            idx       <= '0;
            scan_done <= 1'b0;
            cur_y     <= line_y;
          end
        end
        FS_RD0: begin
          state   <= FS_RD1;
          w1_sent <= 1'b0;
        end
        FS_RD1: begin
          w1_sent <= 1'b1;
          if (w1_sent) begin
            state <= FS_DECIDE;
          end
        end
        FS_DECIDE, FS_WAIT_ROOM: begin
          if (!advance) begin
            state <= FS_WAIT_ROOM;
          end else if (last_idx) begin
            state     <= FS_IDLE;
            scan_done <= 1'b1;
          end else begin
            state <= FS_RD0;
            idx   <= idx + sprite_idx_t'(1);
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  // memory answers one cycle after the request
  always_ff @(posedge clk) begin
    if (state == FS_RD1 && !w1_sent) begin
      hold_w0 <= param_data;
    end
    if (state == FS_RD1 && w1_sent) begin
      hold_w1 <= param_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/sprite_attr_queue.sv */
`default_nettype none
`timescale 1ns/100ps

module sprite_attr_queue
  import sprite_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             push,
  input  wire             rec_enable,
  input  wire tile_size_t rec_size,
  input  wire screen_x_t  rec_x,
  input  wire screen_y_t  rec_y,
  input  wire tile_bank_t rec_tile_bank,
  input  wire tile_idx_t  rec_tile_idx,
  input  wire             rec_pal_mode,
  input  wire pal_bank_t  rec_pal_bank,
  input  wire pal_no_t    rec_pal_no,
  output logic            full,
  sprite_attr_if.source   attr
);

  localparam int REC_W = 2 + $bits(tile_size_t) + $bits(screen_x_t) + $bits(screen_y_t) +
                         $bits(tile_bank_t) + $bits(tile_idx_t) + $bits(pal_bank_t) +
                         $bits(pal_no_t);

  logic [REC_W-1:0] store [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == 2'd2);
  assign attr.empty = (count == 2'd0);
  assign do_push    = push && !full;
  assign do_pop     = attr.pop && !attr.empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      store[wr_ptr] <= {rec_enable, rec_size, rec_x, rec_y, rec_tile_bank, rec_tile_idx,
                        rec_pal_mode, rec_pal_bank, rec_pal_no};
    end
  end

  // simultaneous push and pop keeps the count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      wr_ptr <= wr_ptr ^ do_push;
      rd_ptr <= rd_ptr ^ do_pop;
      count  <= count + 2'(do_push) - 2'(do_pop);
    end
  end

  assign {attr.enable, attr.size, attr.x, attr.y, attr.tile_bank, attr.tile_idx,
          attr.pal_mode, attr.pal_bank, attr.pal_no} = store[rd_ptr];

endmodule

`default_nettype wire

/* rtl/sprite_pixel_pipe.sv */
`default_nettype none
`timescale 1ns/100ps

module sprite_pixel_pipe
  import sprite_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire screen_y_t cur_y,
  sprite_attr_if.sink    attr,
  output logic           idle,
  output logic           tile_en,
  output tile_addr_t     tile_addr,
  input  wire pal_idx_t  tile_data,
  output logic           pal_en,
  output pal_addr_t      pal_addr,
  input  wire color_t    pal_data,
  output logic           line_bank,
  output logic           line_re,
  output screen_x_t      line_raddr,
  input  wire color_t    line_rdata,
  output logic           line_we,
  output screen_x_t      line_waddr,
  output color_t         line_wdata
);

  tile_dim_t  dim;
  tile_dim_t  ox;
  screen_y_t  oy;
  logic       active;
  logic       last_col;
  tile_idx_t  tile_no;
  tile_idx_t  pix_off;
  pal_idx_t   pal_entry;

  logic       s2_v;
  logic       s2_last;
  logic       s2_mode;
  pal_bank_t  s2_bank;
  pal_no_t    s2_no;
  screen_x_t  s2_addr;

  logic       s3_v;
  logic       s3_last;
  screen_x_t  s3_addr;

  logic       s4_v;
  logic       s4_last;
  screen_x_t  s4_addr;
  color_t     s4_src;

  logic       wr_v;
  logic       wr_last;

  function automatic color_t blend(color_t dst, color_t src);
    logic [7:0]  a;
    logic [15:0] mix;
    color_t      res;
    a   = src[31:24];
    res = dst;
    if (a == 8'hff) begin
      res = src;
    end else if (a != 8'h00) begin
      for (int c = 0; c < 3; c++) begin
        mix = dst[8*c +: 8] * (8'd255 - a) + src[8*c +: 8] * a;
        res[8*c +: 8] = mix[15:8];
      end
      res[31:24] = 8'((9'(dst[31:24]) + 9'(a)) >> 1);
    end
    return res;
  endfunction

  assign idle     = !(active || s2_v || s3_v || s4_v || wr_v);
  assign dim      = size_to_dim(attr.size);
  assign oy       = cur_y - attr.y;
  assign last_col = (ox == dim - tile_dim_t'(1));

  // stage 1 builds the tile address from 8x8 tiles laid out row by row
  assign tile_no = attr.tile_idx + tile_idx_t'(ox / HW_TILE_W) +
                   tile_idx_t'((oy / HW_TILE_H) * (dim / HW_TILE_W));
  assign pix_off = tile_idx_t'(tile_no * (HW_TILE_W * HW_TILE_H) +
                               (oy % HW_TILE_H) * HW_TILE_W + ox % HW_TILE_W);
  assign tile_en   = active;
  assign tile_addr = {attr.tile_bank, pix_off};

  // stage 2 forms the palette address
  assign pal_entry = s2_mode ? {s2_no, tile_data[3:0]} : tile_data;
  assign pal_en    = s2_v;
  assign pal_addr  = {s2_bank, pal_entry};

  // stage 3 reads back the destination pixel
  assign line_bank  = cur_y[0];
  assign line_re    = s3_v;
  assign line_raddr = s3_addr;

  assign line_we  = wr_v;
  assign attr.pop = wr_v && wr_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      ox     <= '0;
      s2_v   <= 1'b0;
      s3_v   <= 1'b0;
      s4_v   <= 1'b0;
      wr_v   <= 1'b0;
    end else begin
      if (active) begin
        ox <= ox + tile_dim_t'(1);
        if (last_col) begin
          active <= 1'b0;
        end
      end else if (idle && !attr.empty) begin
        active <= 1'b1;
        ox     <= '0;
      end
      s2_v <= active;
      s3_v <= s2_v;
      s4_v <= s3_v;
      wr_v <= s4_v;
    end
  end

  // side-band follows the pixel down the stages
  always_ff @(posedge clk) begin
    s2_last <= last_col;
    s2_mode <= attr.pal_mode;
    s2_bank <= attr.pal_bank;
    s2_no   <= attr.pal_no;
    s2_addr <= attr.x + screen_x_t'(ox);

    s3_last <= s2_last;
    s3_addr <= s2_addr;

    s4_last <= s3_last;
    s4_addr <= s3_addr;
    s4_src  <= pal_data;

    // stage 4 blends over the pixel read back
    wr_last    <= s4_last;
    line_waddr <= s4_addr;
    line_wdata <= blend(line_rdata, s4_src);
  end

endmodule

`default_nettype wire

/* rtl/sprite_line_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module sprite_line_engine
  import sprite_pkg::*;
#(
  parameter int SPRITE_COUNT = 128
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              line_start,
  input  wire screen_y_t   line_y,
  output logic             line_busy,
  output logic             param_en,
  output param_addr_t      param_addr,
  input  wire param_word_t param_data,
  output logic             tile_en,
  output tile_addr_t       tile_addr,
  input  wire pal_idx_t    tile_data,
  output logic             pal_en,
  output pal_addr_t        pal_addr,
  input  wire color_t      pal_data,
  output logic             line_bank,
  output logic             line_re,
  output screen_x_t        line_raddr,
  input  wire color_t      line_rdata,
  output logic             line_we,
  output screen_x_t        line_waddr,
  output color_t           line_wdata
);

  logic       start_ok;
  logic       scan_done;
  screen_y_t  cur_y;
  logic       push;
  logic       full;
  logic       pipe_idle;
  logic       rec_enable;
  tile_size_t rec_size;
  screen_x_t  rec_x;
  screen_y_t  rec_y;
  tile_bank_t rec_tile_bank;
  tile_idx_t  rec_tile_idx;
  logic       rec_pal_mode;
  pal_bank_t  rec_pal_bank;
  pal_no_t    rec_pal_no;

  sprite_attr_if attr ();

  // a new line only starts once the previous one is fully written
  assign start_ok = line_start && !line_busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_busy <= 1'b0;
    end else if (start_ok) begin
      line_busy <= 1'b1;
    end else if (line_busy && scan_done && attr.empty && pipe_idle) begin
      line_busy <= 1'b0;
    end
  end

  sprite_attr_fetch #(
    .SPRITE_COUNT (SPRITE_COUNT)
  ) u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .line_start    (start_ok),
    .line_y        (line_y),
    .scan_done     (scan_done),
    .cur_y         (cur_y),
    .param_en      (param_en),
    .param_addr    (param_addr),
    .param_data    (param_data),
    .push          (push),
    .rec_enable    (rec_enable),
    .rec_size      (rec_size),
    .rec_x         (rec_x),
    .rec_y         (rec_y),
    .rec_tile_bank (rec_tile_bank),
    .rec_tile_idx  (rec_tile_idx),
    .rec_pal_mode  (rec_pal_mode),
    .rec_pal_bank  (rec_pal_bank),
    .rec_pal_no    (rec_pal_no),
    .full          (full)
  );

  sprite_attr_queue u_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push),
    .rec_enable    (rec_enable),
    .rec_size      (rec_size),
    .rec_x         (rec_x),
    .rec_y         (rec_y),
    .rec_tile_bank (rec_tile_bank),
    .rec_tile_idx  (rec_tile_idx),
    .rec_pal_mode  (rec_pal_mode),
    .rec_pal_bank  (rec_pal_bank),
    .rec_pal_no    (rec_pal_no),
    .full          (full),
    .attr          (attr.source)
  );

  sprite_pixel_pipe u_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .cur_y      (cur_y),
    .attr       (attr.sink),
    .idle       (pipe_idle),
    .tile_en    (tile_en),
    .tile_addr  (tile_addr),
    .tile_data  (tile_data),
    .pal_en     (pal_en),
    .pal_addr   (pal_addr),
    .pal_data   (pal_data),
    .line_bank  (line_bank),
    .line_re    (line_re),
    .line_raddr (line_raddr),
    .line_rdata (line_rdata),
    .line_we    (line_we),
    .line_waddr (line_waddr),
    .line_wdata (line_wdata)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_memories.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_memories
  import sprite_pkg::*;
(
  input  wire              clk,
  input  wire              param_en,
  input  wire param_addr_t param_addr,
  output param_word_t      param_data,
  input  wire              tile_en,
  input  wire tile_addr_t  tile_addr,
  output pal_idx_t         tile_data,
  input  wire              pal_en,
  input  wire pal_addr_t   pal_addr,
  output color_t           pal_data,
  input  wire              line_bank,
  input  wire              line_re,
  input  wire screen_x_t   line_raddr,
  output color_t           line_rdata,
  input  wire              line_we,
  input  wire screen_x_t   line_waddr,
  input  wire color_t      line_wdata,
  input  wire              line_clear
);

  // loaded by the testbench while the engine is idle
  param_word_t param_mem [256];
  pal_idx_t    tile_mem [65536];
  color_t      pal_mem [1024];
  color_t      line_mem [2][512];

  // background pattern over bank and address
  function automatic color_t clear_value(logic bank, screen_x_t addr);
    return color_t'({22'd0, bank, addr} * 32'h9e3779b1) ^ 32'h3c5a96e1;
  endfunction

  initial begin
    param_data = '0;
    tile_data  = '0;
    pal_data   = '0;
    line_rdata = '0;
  end

  always @(posedge clk) begin
    if (param_en) begin
      param_data <= param_mem[param_addr];
    end
    if (tile_en) begin
      tile_data <= tile_mem[tile_addr];
    end
    if (pal_en) begin
      pal_data <= pal_mem[pal_addr];
    end
  end

  // a read returns the old contents and a clear takes one edge
  always @(posedge clk) begin
    if (line_re) begin
      line_rdata <= line_mem[line_bank][line_raddr];
    end
    if (line_clear) begin
      for (int b = 0; b < 2; b++) begin
        for (int a = 0; a < 512; a++) begin
          line_mem[1'(b)][9'(a)] = clear_value(1'(b), 9'(a));
        end
      end
    end else if (line_we) begin
      line_mem[line_bank][line_waddr] = line_wdata;
    end
  end

endmodule

`default_nettype wire

/* sim/sprite_line_engine_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module sprite_line_engine_tb
  import sprite_pkg::*;
();

  localparam int          PERIOD_NS    = 40;
  localparam int          RESET_CYCLES = 16;
  localparam int          N_SPRITES    = 8;
  localparam int          N_ROWS       = 7;
  localparam logic [31:0] SEED         = 32'h7858e4de;

  localparam logic [1:0] K_OPAQUE = 2'd0;
  localparam logic [1:0] K_MODE1  = 2'd1;
  localparam logic [1:0] K_MISS   = 2'd2;
  localparam logic [1:0] K_BLEND  = 2'd3;

  typedef struct packed {
    screen_y_t  line;
    logic [7:0] seed_off;
    logic [1:0] kind;
  } row_t;

  // line, scene seed offset, scene kind
  localparam row_t TESTS [N_ROWS] = '{
    {8'd20,  8'h11, K_OPAQUE},
    {8'd37,  8'h22, K_OPAQUE},
    {8'd50,  8'h33, K_MODE1},
    {8'd90,  8'h44, K_MISS},
    {8'd64,  8'h55, K_BLEND},
    {8'd101, 8'h66, K_BLEND},
    {8'd200, 8'h77, K_BLEND}
  };

  logic        clk;
  logic        rst_n;
  logic        line_start;
  screen_y_t   line_y;
  logic        line_clear;
  logic        line_busy;
  logic        param_en;
  param_addr_t param_addr;
  param_word_t param_data;
  logic        tile_en;
  tile_addr_t  tile_addr;
  pal_idx_t    tile_data;
  logic        pal_en;
  pal_addr_t   pal_addr;
  color_t      pal_data;
  logic        line_bank;
  logic        line_re;
  screen_x_t   line_raddr;
  color_t      line_rdata;
  logic        line_we;
  screen_x_t   line_waddr;
  color_t      line_wdata;

  logic [31:0] rng;
  int          errs;
  int          pass_cnt;
  int          fail_cnt;
  color_t      ref_line [2][512];

  tb_clock #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) clk_gen (.*);

  tb_memories mems (.*);

  sprite_line_engine #(
    .SPRITE_COUNT (N_SPRITES)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_start (line_start),
    .line_y     (line_y),
    .line_busy  (line_busy),
    .param_en   (param_en),
    .param_addr (param_addr),
    .param_data (param_data),
    .tile_en    (tile_en),
    .tile_addr  (tile_addr),
    .tile_data  (tile_data),
    .pal_en     (pal_en),
    .pal_addr   (pal_addr),
    .pal_data   (pal_data),
    .line_bank  (line_bank),
    .line_re    (line_re),
    .line_raddr (line_raddr),
    .line_rdata (line_rdata),
    .line_we    (line_we),
    .line_waddr (line_waddr),
    .line_wdata (line_wdata)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // alpha 0 keeps the destination and alpha 255 replaces it
  function automatic color_t blend_ref(color_t dst, color_t src);
    int     a;
    color_t res;
    a = int'(src[31:24]);
    if (a == 0) begin
      return dst;
    end
    if (a == 255) begin
      return src;
    end
    for (int c = 0; c < 3; c++) begin
      res[8*c +: 8] = 8'((int'(dst[8*c +: 8]) * (255 - a) + int'(src[8*c +: 8]) * a) / 256);
    end
    res[31:24] = 8'((int'(dst[31:24]) + a) / 2);
    return res;
  endfunction

  task automatic check_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    if (errs == 0) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d mismatches", name, errs);
    end
  endtask

  task automatic build_scene(input row_t row);
    logic [31:0] r;
    logic [31:0] r2;
    logic [1:0]  size;
    logic        en;
    logic        mode;
    int          dim;
    int          off;
    int          xv;
    int          yv;
    int          cursor;
    color_t      c;
    rng = SEED ^ {24'd0, row.seed_off};
    for (int a = 0; a < 65536; a++) begin
      mems.tile_mem[16'(a)] = pal_idx_t'(next_rand());
    end
    for (int a = 0; a < 1024; a++) begin
      c = next_rand();
      if (row.kind == K_OPAQUE || row.kind == K_MODE1) begin
        c[31:24] = 8'hff;
      end else if (c[1:0] == 2'd0) begin
        c[31:24] = 8'h00;
      end else if (c[1:0] == 2'd1) begin
        c[31:24] = 8'hff;
      end
      mems.pal_mem[10'(a)] = c;
    end
    for (int a = 0; a < 256; a++) begin
      mems.param_mem[8'(a)] = next_rand();
    end
    cursor = int'(next_rand() % 128);
    for (int i = 0; i < N_SPRITES; i++) begin
      r    = next_rand();
      r2   = next_rand();
      size = (row.kind == K_OPAQUE) ? 2'(i % 4) : r[1:0];
      dim  = 8 << size;
      off  = int'(r[15:8]) % dim;
      if (off > int'(row.line)) begin
        off = int'(row.line);
      end
      yv   = int'(row.line) - off;
      xv   = int'(r[24:16]);
      en   = 1'b1;
      mode = r[31];
      case (row.kind)
        K_OPAQUE, K_MODE1: begin
          // side by side so the all-size row has no overlap
          xv     = cursor;
          cursor = cursor + dim + 4;
          mode   = (row.kind == K_MODE1);
        end
        K_MISS: begin
          if (i % 3 == 0) begin
            en = 1'b0;
          end else if (i % 3 == 1 || int'(row.line) < dim + 16) begin
            yv = int'(row.line) + 1 + int'(r[5:2]);
          end else begin
            yv = int'(row.line) - dim - int'(r[5:2]);
          end
        end
        default: begin
          // stacked near the right edge, some rows wrap past 511
          xv = 440 + int'(r[21:16]);
        end
      endcase
      // noise in the unused bits of both words
      mems.param_mem[8'(2 * i)] = {en, r2[30:26], size, r2[23:17], 9'(xv), 8'(yv)};
      r2[6] = mode;
      mems.param_mem[8'(2 * i + 1)] = r2;
    end
  endtask

  task automatic predict_line(input screen_y_t line);
    param_word_t w0;
    param_word_t w1;
    logic        bank;
    int          dim;
    int          sy;
    int          oy;
    int          tno;
    int          off;
    int          pidx;
    int          paddr;
    int          wa;
    bank = line[0];
    for (int i = 0; i < N_SPRITES; i++) begin
      w0  = mems.param_mem[8'(2 * i)];
      w1  = mems.param_mem[8'(2 * i + 1)];
      dim = 8 << w0[25:24];
      sy  = int'(w0[7:0]);
      if (w0[31] && int'(line) >= sy && int'(line) < sy + dim) begin
        oy = int'(line) - sy;
        for (int ox = 0; ox < dim; ox++) begin
          tno  = int'(w1[27:16]) + ox / 8 + (oy / 8) * (dim / 8);
          off  = (tno * 64 + (oy % 8) * 8 + ox % 8) % 4096;
          pidx = int'(mems.tile_mem[{w1[31:28], 12'(off)}]);
          if (w1[6]) begin
            paddr = int'(w1[5:4]) * 256 + int'(w1[3:0]) * 16 + pidx % 16;
          end else begin
            paddr = int'(w1[5:4]) * 256 + pidx;
          end
          wa = (int'(w0[16:8]) + ox) % 512;
          ref_line[bank][9'(wa)] = blend_ref(ref_line[bank][9'(wa)],
                                             mems.pal_mem[10'(paddr)]);
        end
      end
    end
  endtask

  task automatic run_row(input int r);
    row_t row;
    row  = TESTS[r];
    errs = 0;
    build_scene(row);
    @(posedge clk);
    line_clear <= 1'b1;
    @(posedge clk);
    line_clear <= 1'b0;
    @(negedge clk);
    for (int b = 0; b < 2; b++) begin
      for (int a = 0; a < 512; a++) begin
        ref_line[1'(b)][9'(a)] = mems.line_mem[1'(b)][9'(a)];
      end
    end
    predict_line(row.line);
    @(posedge clk);
    line_start <= 1'b1;
    line_y     <= row.line;
    @(posedge clk);
    line_start <= 1'b0;
    @(negedge clk);
    check_flag("line_busy", line_busy, 1'b1);
    // a second start mid-line must be ignored
    @(posedge clk);
    line_start <= 1'b1;
    line_y     <= row.line ^ 8'h01;
    @(posedge clk);
    line_start <= 1'b0;
    @(negedge clk);
    while (line_busy) begin
      @(negedge clk);
    end
    check_flag("line_we", line_we, 1'b0);
    for (int b = 0; b < 2; b++) begin
      for (int a = 0; a < 512; a++) begin
        check_color($sformatf("line_buf[%0d][%0d]", b, a),
                    mems.line_mem[1'(b)][9'(a)], ref_line[1'(b)][9'(a)]);
      end
    end
    finish_test($sformatf("row %0d line %0d kind %0d", r, row.line, row.kind));
  endtask

  // longest row is eight 64-pixel sprites
  initial begin
    #((RESET_CYCLES + N_ROWS * N_SPRITES * 80 + 64) * PERIOD_NS);
    $display("watchdog: the line engine did not finish in time");
    $display("sim failed");
    $finish;
  end

  initial begin
    line_start = 1'b0;
    line_y     = '0;
    line_clear = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    errs       = 0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag("line_busy", line_busy, 1'b0);
    check_flag("line_we", line_we, 1'b0);
    check_flag("param_en", param_en, 1'b0);
    check_flag("tile_en", tile_en, 1'b0);
    check_flag("pal_en", pal_en, 1'b0);
    finish_test("after reset");
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    $display("tests: %0d ok, %0d failing", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sprite_line_engine.f */
rtl/sprite_pkg.sv
rtl/sprite_attr_if.sv
rtl/sprite_attr_fetch.sv
rtl/sprite_attr_queue.sv
rtl/sprite_pixel_pipe.sv
rtl/sprite_line_engine.sv
sim/tb_clock.sv
sim/tb_memories.sv
sim/sprite_line_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the sprite line engine testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module sprite_line_engine_tb \
  -f sprite_line_engine.f \
  -o sprite_line_engine_sim

./obj_dir/sprite_line_engine_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
